//--- Bender.yml
package:
  name: sd_adma

sources:
  - src/adma_pkg.sv
  - src/adma_descriptor_fsm.sv
  - src/axi_read_engine.sv
  - src/axi_write_engine.sv
  - src/sd_adma_top.sv
  - target: test
    files:
      - tests/sd_adma_checker.sv
      - tests/sd_adma_tb.sv

//--- src/adma_descriptor_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module adma_descriptor_fsm (
  input  wire                 clock,
  input  wire                 reset,
  input  wire                 start,
  input  wire [31:0]          desc_base,
  input  wire                 to_mem,
  input  wire                 gap_request,
  input  wire                 irq_clear,
  input  wire [31:0]          desc_beat,
  input  wire                 desc_beat_valid,
  input  wire                 rd_done,
  input  wire                 wr_done,
  output adma_pkg::move_cmd_t cmd,
  output logic                rd_cmd_valid,
  output logic                wr_cmd_valid,
  output adma_pkg::dma_irq_t  irq
);

  import adma_pkg::*;

  // Stop, fetch, change address, transfer
  typedef enum logic [1:0] {
    ST_STOP,
    ST_FDS,
    ST_CADR,
    ST_TFR
  } adma_state_t;

  adma_state_t         state;
  adma_desc_t          desc_line;
  logic [31:0]         desc_ptr;
  logic                beat_sel;
  logic [31:0]         next_ptr;
  logic [16:0]         len_bytes;
  logic [16:0]         len_round;
  logic [BURSTS_W-1:0] tran_bursts;

  ////////////////////
  // Line decode
  ////////////////////

  always_comb begin
    // Zero length means a full 64 KiB
    len_bytes = (desc_line.length == 16'h0000) ? 17'h10000 : {1'b0, desc_line.length};
    len_round = len_bytes + 17'(BURST_BYTES - 1);
    // Whole bursts, rounded up
    tran_bursts = BURSTS_W'(len_round >> $clog2(BURST_BYTES));
    if (desc_line.act == ACT_LINK) begin
      next_ptr = desc_line.address;
    end else begin
      next_ptr = desc_ptr + 32'(DESC_BYTES);
    end
  end

  ////////////////////
  // Walk sequencing
  ////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      state        <= ST_STOP;
      desc_ptr     <= '0;
      beat_sel     <= 1'b0;
      cmd          <= '0;
      rd_cmd_valid <= 1'b0;
      wr_cmd_valid <= 1'b0;
      irq          <= '0;
    end else begin
      rd_cmd_valid <= 1'b0;
      wr_cmd_valid <= 1'b0;
      if (irq_clear) begin
        irq <= '0;
      end
      case (state)
        ST_STOP: begin
          if (start) begin
            desc_ptr     <= desc_base;
            beat_sel     <= 1'b0;
            cmd          <= '{kind: MOVE_FETCH, addr: desc_base, bursts: '0};
            rd_cmd_valid <= 1'b1;
            state        <= ST_FDS;
          end
        end
        ST_FDS: begin
          // Low word first, then the address word
          if (desc_beat_valid) begin
            beat_sel <= ~beat_sel;
          end
          if (rd_done) begin
            state <= ST_CADR;
          end
        end
        ST_CADR: begin
          if (!desc_line.valid) begin
            irq.error <= 1'b1;
            state     <= ST_STOP;
          end else begin
            desc_ptr <= next_ptr;
            if (desc_line.act == ACT_TRAN) begin
              cmd.kind   <= to_mem ? MOVE_TO_MEM : MOVE_TO_CARD;
              cmd.addr   <= desc_line.address;
              cmd.bursts <= tran_bursts;
              rd_cmd_valid <= !to_mem;
              wr_cmd_valid <= to_mem;
              state        <= ST_TFR;
            end else if (desc_line.end_flag) begin
              // Nop or Link ends quietly
              state <= ST_STOP;
            end else begin
              beat_sel     <= 1'b0;
              cmd          <= '{kind: MOVE_FETCH, addr: next_ptr, bursts: '0};
              rd_cmd_valid <= 1'b1;
              state        <= ST_FDS;
            end
          end
        end
        ST_TFR: begin
          if (rd_done || wr_done) begin
            if (desc_line.end_flag || gap_request) begin
              irq.complete <= 1'b1;
              state        <= ST_STOP;
            end else begin
              beat_sel     <= 1'b0;
              cmd          <= '{kind: MOVE_FETCH, addr: desc_ptr, bursts: '0};
              rd_cmd_valid <= 1'b1;
              state        <= ST_FDS;
            end
          end
        end
        default: begin
          state <= ST_STOP;
        end
      endcase
    end
  end

  // Descriptor line assembly
  always_ff @(posedge clock) begin
    if (state == ST_FDS && desc_beat_valid) begin
      if (beat_sel) begin
        desc_line[63:32] <= desc_beat;
      end else begin
        desc_line[31:0] <= desc_beat;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/adma_pkg.sv
`default_nettype none

package adma_pkg;

  ////////////////////
  // Transfer geometry
  ////////////////////

  // Data bursts are 16 words of 4 bytes
  localparam int BURST_BEATS = 16;
  localparam int BURST_BYTES = 64;

  // A descriptor line is two words
  localparam int DESC_BYTES  = 8;
  localparam int FETCH_BEATS = 2;

  // Counter widths
  localparam int BURSTS_W   = 12;
  localparam int WORD_CNT_W = 16;
  localparam int BEAT_IDX_W = $clog2(BURST_BEATS);

  // AXI attribute codes
  localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;

  // ADMA2 action field
  localparam logic [1:0] ACT_NOP  = 2'b00;
  localparam logic [1:0] ACT_TRAN = 2'b10;
  localparam logic [1:0] ACT_LINK = 2'b11;

  ////////////////////
  // Shared types
  ////////////////////

  // Descriptor line, low word arrives first
  typedef struct packed {
    logic [31:0] address;
    logic [15:0] length;
    logic [9:0]  reserved_hi;
    logic [1:0]  act;
    logic        reserved_lo;
    logic        int_flag;
    logic        end_flag;
    logic        valid;
  } adma_desc_t;

  typedef enum logic [1:0] {
    MOVE_FETCH,
    MOVE_TO_CARD,
    MOVE_TO_MEM
  } move_kind_t;

  // Bursts is ignored for a fetch
  typedef struct packed {
    move_kind_t          kind;
    logic [31:0]         addr;
    logic [BURSTS_W-1:0] bursts;
  } move_cmd_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [7:0]  len;
  } axi_addr_t;

  typedef struct packed {
    logic complete;
    logic error;
  } dma_irq_t;

endpackage

`default_nettype wire

//--- src/axi_read_engine.sv
`timescale 1ns/1ps
`default_nettype none

module axi_read_engine (
  input  wire                 clock,
  input  wire                 reset,
  input  adma_pkg::move_cmd_t cmd,
  input  wire                 cmd_valid,
  output adma_pkg::axi_addr_t ar,
  output logic                ar_valid,
  input  wire                 ar_ready,
  input  wire [31:0]          r_data,
  input  wire                 r_valid,
  input  wire                 r_last,
  output logic                r_ready,
  output logic [31:0]         desc_beat,
  output logic                desc_beat_valid,
  output logic [31:0]         card_word,
  output logic                card_word_valid,
  output logic                done
);

  import adma_pkg::*;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA
  } rd_state_t;

  rd_state_t           state;
  logic                fetch_q;
  logic [31:0]         addr_q;
  logic [BURSTS_W-1:0] bursts_left;
  logic [31:0]         beat_q;

  // Address channel payload held from registers
  assign ar.addr = addr_q;
  assign ar.len  = fetch_q ? 8'(FETCH_BEATS - 1) : 8'(BURST_BEATS - 1);

  // One registered beat feeds both sinks
  assign desc_beat = beat_q;
  assign card_word = beat_q;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state           <= RD_IDLE;
      bursts_left     <= '0;
      ar_valid        <= 1'b0;
      r_ready         <= 1'b0;
      desc_beat_valid <= 1'b0;
      card_word_valid <= 1'b0;
      done            <= 1'b0;
    end else begin
      desc_beat_valid <= 1'b0;
      card_word_valid <= 1'b0;
      done            <= 1'b0;
      case (state)
        RD_IDLE: begin
          if (cmd_valid) begin
            bursts_left <= (cmd.kind == MOVE_FETCH) ? BURSTS_W'(1) : cmd.bursts;
            ar_valid    <= 1'b1;
            state       <= RD_ADDR;
          end
        end
        RD_ADDR: begin
          if (ar_ready) begin
            ar_valid <= 1'b0;
            r_ready  <= 1'b1;
            state    <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (r_valid) begin
            desc_beat_valid <= fetch_q;
            card_word_valid <= !fetch_q;
            if (r_last) begin
              r_ready     <= 1'b0;
              bursts_left <= bursts_left - 1'b1;
              if (bursts_left == BURSTS_W'(1)) begin
                done  <= 1'b1;
                state <= RD_IDLE;
              end else begin
                // Next 64-byte burst
                ar_valid <= 1'b1;
                state    <= RD_ADDR;
              end
            end
          end
        end
        default: begin
          state <= RD_IDLE;
        end
      endcase
    end
  end

  ////////////////////
  // Payload registers
  ////////////////////

  always_ff @(posedge clock) begin
    if (state == RD_IDLE && cmd_valid) begin
      fetch_q <= (cmd.kind == MOVE_FETCH);
      addr_q  <= cmd.addr;
    end else if (state == RD_DATA && r_valid && r_last) begin
      addr_q <= addr_q + 32'(BURST_BYTES);
    end
    if (r_valid && r_ready) begin
      beat_q <= r_data;
    end
  end

endmodule

`default_nettype wire

//--- src/axi_write_engine.sv
`timescale 1ns/1ps
`default_nettype none

module axi_write_engine (
  input  wire                 clock,
  input  wire                 reset,
  input  adma_pkg::move_cmd_t cmd,
  input  wire                 cmd_valid,
  input  wire                 card_we,
  input  wire [31:0]          fifo_head,
  output adma_pkg::axi_addr_t aw,
  output logic                aw_valid,
  input  wire                 aw_ready,
  output logic [31:0]         w_data,
  output logic                w_valid,
  output logic                w_last,
  input  wire                 w_ready,
  output logic                fifo_pop,
  output logic                done
);

  import adma_pkg::*;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_WAIT,
    WR_ADDR,
    WR_DATA
  } wr_state_t;

  wr_state_t             state;
  logic [31:0]           addr_q;
  logic [BURSTS_W-1:0]   bursts_left;
  logic [BEAT_IDX_W-1:0] beat_idx;
  logic [WORD_CNT_W-1:0] fill_cnt;
  logic [WORD_CNT_W-1:0] sent_cnt;
  logic                  we_q1;
  logic                  we_q2;
  logic                  we_fall;
  logic                  w_fire;

  ////////////////////
  // Card FIFO fill count
  ////////////////////

  // One word per falling edge of card_we
  assign we_fall = we_q2 && !we_q1;

  always_ff @(posedge clock) begin
    if (!reset) begin
      we_q1    <= 1'b0;
      we_q2    <= 1'b0;
      fill_cnt <= '0;
    end else begin
      we_q1 <= card_we;
      we_q2 <= we_q1;
      if (cmd_valid) begin
        fill_cnt <= WORD_CNT_W'(we_fall);
      end else if (we_fall) begin
        fill_cnt <= fill_cnt + 1'b1;
      end
    end
  end

  ////////////////////
  // AW and W channels
  ////////////////////

  assign aw.addr  = addr_q;
  assign aw.len   = 8'(BURST_BEATS - 1);
  assign w_data   = fifo_head;
  assign w_fire   = w_valid && w_ready;
  assign fifo_pop = w_fire;
  assign w_last   = w_valid && (beat_idx == BEAT_IDX_W'(BURST_BEATS - 1));

  always_ff @(posedge clock) begin
    if (!reset) begin
      state       <= WR_IDLE;
      bursts_left <= '0;
      beat_idx    <= '0;
      sent_cnt    <= '0;
      aw_valid    <= 1'b0;
      w_valid     <= 1'b0;
      done        <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        WR_IDLE: begin
          if (cmd_valid) begin
            bursts_left <= cmd.bursts;
            sent_cnt    <= '0;
            state       <= WR_WAIT;
          end
        end
        WR_WAIT: begin
          // Whole burst must be in the FIFO
          if (fill_cnt >= sent_cnt + WORD_CNT_W'(BURST_BEATS)) begin
            aw_valid <= 1'b1;
            state    <= WR_ADDR;
          end
        end
        WR_ADDR: begin
          if (aw_ready) begin
            aw_valid <= 1'b0;
            w_valid  <= 1'b1;
            beat_idx <= '0;
            state    <= WR_DATA;
          end
        end
        WR_DATA: begin
          if (w_fire) begin
            sent_cnt <= sent_cnt + 1'b1;
            beat_idx <= beat_idx + 1'b1;
            if (w_last) begin
              w_valid     <= 1'b0;
              bursts_left <= bursts_left - 1'b1;
              if (bursts_left == BURSTS_W'(1)) begin
                done  <= 1'b1;
                state <= WR_IDLE;
              end else begin
                state <= WR_WAIT;
              end
            end
          end
        end
        default: begin
          state <= WR_IDLE;
        end
      endcase
    end
  end

  // Burst address, 64 bytes per burst
  always_ff @(posedge clock) begin
    if (state == WR_IDLE && cmd_valid) begin
      addr_q <= cmd.addr;
    end else if (w_fire && w_last) begin
      addr_q <= addr_q + 32'(BURST_BYTES);
    end
  end

endmodule

`default_nettype wire

//--- src/sd_adma_top.sv
`timescale 1ns/1ps
`default_nettype none

module sd_adma_top (
  input  wire                 clock,
  input  wire                 reset,
  input  wire                 start,
  input  wire [31:0]          desc_base,
  input  wire                 to_mem,
  input  wire                 gap_request,
  input  wire                 irq_clear,
  output adma_pkg::dma_irq_t  irq,
  output adma_pkg::axi_addr_t ar,
  output logic                ar_valid,
  input  wire                 ar_ready,
  input  wire [31:0]          r_data,
  input  wire                 r_valid,
  input  wire                 r_last,
  output logic                r_ready,
  output adma_pkg::axi_addr_t aw,
  output logic                aw_valid,
  input  wire                 aw_ready,
  output logic [31:0]         w_data,
  output logic                w_valid,
  input  wire                 w_ready,
  output logic                w_last,
  output logic [2:0]          ax_size,
  output logic [1:0]          ax_burst,
  output logic [31:0]         card_word,
  output logic                card_word_valid,
  input  wire                 card_we,
  input  wire [31:0]          fifo_head,
  output logic                fifo_pop
);

  import adma_pkg::*;

  move_cmd_t   cmd;
  logic        rd_cmd_valid;
  logic        wr_cmd_valid;
  logic [31:0] desc_beat;
  logic        desc_beat_valid;
  logic        rd_done;
  logic        wr_done;

  // Word beats, incrementing bursts on both channels
  assign ax_size  = AXI_SIZE_WORD;
  assign ax_burst = AXI_BURST_INCR;

  ////////////////////
  // Engines
  ////////////////////

  adma_descriptor_fsm u_desc_fsm (
    .clock          (clock),
    .reset          (reset),
    .start          (start),
    .desc_base      (desc_base),
    .to_mem         (to_mem),
    .gap_request    (gap_request),
    .irq_clear      (irq_clear),
    .desc_beat      (desc_beat),
    .desc_beat_valid(desc_beat_valid),
    .rd_done        (rd_done),
    .wr_done        (wr_done),
    .cmd            (cmd),
    .rd_cmd_valid   (rd_cmd_valid),
    .wr_cmd_valid   (wr_cmd_valid),
    .irq            (irq)
  );

  axi_read_engine u_rd_engine (
    .clock          (clock),
    .reset          (reset),
    .cmd            (cmd),
    .cmd_valid      (rd_cmd_valid),
    .ar             (ar),
    .ar_valid       (ar_valid),
    .ar_ready       (ar_ready),
    .r_data         (r_data),
    .r_valid        (r_valid),
    .r_last         (r_last),
    .r_ready        (r_ready),
    .desc_beat      (desc_beat),
    .desc_beat_valid(desc_beat_valid),
    .card_word      (card_word),
    .card_word_valid(card_word_valid),
    .done           (rd_done)
  );

  axi_write_engine u_wr_engine (
    .clock    (clock),
    .reset    (reset),
    .cmd      (cmd),
    .cmd_valid(wr_cmd_valid),
    .card_we  (card_we),
    .fifo_head(fifo_head),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w_data   (w_data),
    .w_valid  (w_valid),
    .w_last   (w_last),
    .w_ready  (w_ready),
    .fifo_pop (fifo_pop),
    .done     (wr_done)
  );

endmodule

`default_nettype wire

//--- tests/sd_adma_checker.sv
`timescale 1ns/1ps
`default_nettype none

module adma_axi_checker (
  input wire                 clock,
  input wire                 reset,
  input adma_pkg::move_cmd_t cmd,
  input adma_pkg::axi_addr_t ar,
  input wire                 ar_valid,
  input wire                 ar_ready,
  input adma_pkg::axi_addr_t aw,
  input wire                 aw_valid,
  input wire                 aw_ready,
  input wire [31:0]          w_data,
  input wire                 w_valid,
  input wire                 w_ready,
  input wire                 w_last
);

  import adma_pkg::*;

  logic [BEAT_IDX_W-1:0] w_beat_cnt;
  int                    fail_count = 0;

  // Beat position inside the current W burst
  always_ff @(posedge clock) begin
    if (!reset) begin
      w_beat_cnt <= '0;
    end else if (w_valid && w_ready) begin
      w_beat_cnt <= w_last ? '0 : w_beat_cnt + 1'b1;
    end
  end

  ////////////////////
  // Channel rules
  ////////////////////

  ar_hold: assert property (@(posedge clock) disable iff (!reset)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar))
    else begin
      $error("AR valid or payload dropped before ready");
      fail_count++;
    end

  aw_hold: assert property (@(posedge clock) disable iff (!reset)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw))
    else begin
      $error("AW valid or payload dropped before ready");
      fail_count++;
    end

  w_hold: assert property (@(posedge clock) disable iff (!reset)
    w_valid && !w_ready |=> w_valid && $stable(w_data) && $stable(w_last))
    else begin
      $error("W valid or payload dropped before ready");
      fail_count++;
    end

  w_last_pos: assert property (@(posedge clock) disable iff (!reset)
    w_valid |-> (w_last == (w_beat_cnt == BEAT_IDX_W'(BURST_BEATS - 1))))
    else begin
      $error("w_last not on the 16th beat");
      fail_count++;
    end

  // Two beats for a descriptor fetch, sixteen for data
  ar_len_legal: assert property (@(posedge clock) disable iff (!reset)
    ar_valid |-> (ar.len == ((cmd.kind == MOVE_FETCH) ? 8'd1 : 8'd15)))
    else begin
      $error("AR length does not match the move in progress");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- tests/sd_adma_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sd_adma_tb;

  import adma_pkg::*;

  localparam int TEST_BUDGET = 2000;
  localparam int WATCHDOG_CYCLES = (8 + 5 * TEST_BUDGET) * 4;

  logic clock, reset, start, to_mem, gap_request, irq_clear;
  logic [31:0] desc_base;
  dma_irq_t irq;
  axi_addr_t ar, aw;
  logic ar_valid, ar_ready, r_valid, r_last, r_ready;
  logic [31:0] r_data, w_data, card_word, fifo_head;
  logic aw_valid, aw_ready, w_valid, w_ready, w_last;
  logic [2:0] ax_size;
  logic [1:0] ax_burst;
  logic card_word_valid, card_we, fifo_pop;

  logic [31:0] mem [logic [31:0]];
  logic [31:0] lcg_state = 32'd68525;
  logic [31:0] ar_log[$];
  logic [31:0] card_rx[$];
  logic [31:0] card_q[$];
  logic [31:0] rd_addr, wr_addr;
  int rd_left, rd_len, fetch_count, errors, tests_run, tests_failed;
  logic rd_active;

  sd_adma_top DUT (.*);

  bind sd_adma_top adma_axi_checker u_axi_checker (
    .clock(clock), .reset(reset), .cmd(cmd), .ar(ar), .ar_valid(ar_valid),
    .ar_ready(ar_ready), .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
    .w_data(w_data), .w_valid(w_valid), .w_ready(w_ready), .w_last(w_last)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Unwritten memory reads back a pattern of its address
  function automatic logic [31:0] mem_read(input logic [31:0] addr);
    return mem.exists(addr) ? mem[addr] : (addr ^ 32'h5a5a_c3c3);
  endfunction

  function automatic logic [31:0] desc_word(input logic vld, input logic last,
                                            input logic [1:0] act, input logic [15:0] len);
    return {len, 10'b0, act, 1'b0, 1'b0, last, vld};
  endfunction

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  ////////////////////
  // Memory and card models
  ////////////////////

  always @(negedge clock) begin
    if (card_word_valid) begin
      card_rx.push_back(card_word);
    end
    fifo_head = (card_q.size() > 0) ? card_q[0] : 32'h0;
    // R beats, with random gaps
    r_valid = 1'b0;
    r_last  = 1'b0;
    if (rd_active && r_ready && lcg_next() >= 32'h4000_0000) begin
      r_valid = 1'b1;
      r_data  = mem_read(rd_addr);
      r_last  = (rd_left == 1);
      rd_addr = rd_addr + 32'd4;
      rd_left = rd_left - 1;
      if (rd_left == 0) begin
        rd_active = 1'b0;
        if (rd_len == 2) begin
          fetch_count++;
        end
      end
    end
    ar_ready = !rd_active && (lcg_next() >= 32'h4000_0000);
    if (ar_valid && ar_ready) begin
      ar_log.push_back(ar.addr);
      if (ax_size !== 3'b010) begin
        report_mismatch("ax_size", 32'h2, ax_size);
      end
      if (ax_burst !== 2'b01) begin
        report_mismatch("ax_burst", 32'h1, ax_burst);
      end
      rd_addr   = ar.addr;
      rd_len    = int'(ar.len) + 1;
      rd_left   = rd_len;
      rd_active = 1'b1;
    end
    aw_ready = (lcg_next() >= 32'h4000_0000);
    if (aw_valid && aw_ready) begin
      wr_addr = aw.addr;
    end
    w_ready = (lcg_next() >= 32'h4000_0000);
  end

  // W beats and FIFO pops take effect on the rising edge
  always @(posedge clock) begin
    if (w_valid && w_ready) begin
      mem[wr_addr] = w_data;
      wr_addr      = wr_addr + 32'd4;
    end
    if (fifo_pop && card_q.size() > 0) begin
      void'(card_q.pop_front());
    end
  end

  ////////////////////
  // Test helpers
  ////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
    errors++;
  endtask

  task automatic begin_walk(input logic [31:0] base);
    @(negedge clock);
    irq_clear = 1'b1;
    ar_log.delete();
    card_rx.delete();
    @(negedge clock);
    irq_clear = 1'b0;
    desc_base = base;
    start     = 1'b1;
    @(negedge clock);
    start = 1'b0;
  endtask

  task automatic wait_irq();
    int n;
    n = 0;
    while (irq == '0 && n < TEST_BUDGET) begin
      @(negedge clock);
      n++;
    end
    if (irq == '0) begin
      $display("Timed out waiting for an interrupt at %0t", $time);
      errors++;
    end
  endtask

  task automatic fill_data(input logic [31:0] addr, input int words);
    for (int i = 0; i < words; i++) begin
      mem[addr + 32'(4 * i)] = lcg_next();
    end
  endtask

  task automatic check_card(input logic [31:0] addr, input int words);
    if (card_rx.size() != words) begin
      report_mismatch("card word count", words, card_rx.size());
    end else begin
      for (int i = 0; i < words; i++) begin
        if (card_rx[i] != mem_read(addr + 32'(4 * i))) begin
          report_mismatch("card_word", mem_read(addr + 32'(4 * i)), card_rx[i]);
        end
      end
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d mismatches", name, errors - errors_before);
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic test_to_card();
    int e0;
    e0 = errors;
    mem[32'h1000] = desc_word(1'b1, 1'b1, ACT_TRAN, 16'd128);
    mem[32'h1004] = 32'h4000;
    fill_data(32'h4000, 32);
    begin_walk(32'h1000);
    wait_irq();
    check_card(32'h4000, 32);
    if (irq.complete !== 1'b1) report_mismatch("irq.complete", 1, irq.complete);
    if (irq.error !== 1'b0) report_mismatch("irq.error", 0, irq.error);
    finish_test("memory_to_card", e0);
  endtask

  task automatic test_to_mem();
    int e0;
    int fetches;
    logic [31:0] words[16];
    e0 = errors;
    mem[32'h2000] = desc_word(1'b1, 1'b1, ACT_TRAN, 16'd64);
    mem[32'h2004] = 32'h6000;
    to_mem  = 1'b1;
    fetches = fetch_count;
    begin_walk(32'h2000);
    while (fetch_count == fetches) @(negedge clock);
    repeat (4) @(negedge clock);
    // One card_we pulse per word pushed into the card FIFO
    for (int i = 0; i < 16; i++) begin
      words[i] = lcg_next();
      card_q.push_back(words[i]);
      card_we = 1'b1;
      @(negedge clock);
      card_we = 1'b0;
      @(negedge clock);
    end
    wait_irq();
    for (int i = 0; i < 16; i++) begin
      if (mem_read(32'h6000 + 32'(4 * i)) != words[i]) begin
        report_mismatch("mem word", words[i], mem_read(32'h6000 + 32'(4 * i)));
      end
    end
    if (irq.complete !== 1'b1) report_mismatch("irq.complete", 1, irq.complete);
    to_mem = 1'b0;
    finish_test("card_to_memory", e0);
  endtask

  task automatic test_chain();
    int e0;
    logic [31:0] exp_ar[3];
    e0 = errors;
    exp_ar = '{32'h3000, 32'h3008, 32'h8000};
    mem[32'h3000] = desc_word(1'b1, 1'b0, ACT_NOP, 16'd0);
    mem[32'h3004] = 32'h0;
    mem[32'h3008] = desc_word(1'b1, 1'b0, ACT_LINK, 16'd0);
    mem[32'h300c] = 32'h8000;
    mem[32'h8000] = desc_word(1'b1, 1'b1, ACT_TRAN, 16'd128);
    mem[32'h8004] = 32'h4800;
    fill_data(32'h4800, 32);
    begin_walk(32'h3000);
    wait_irq();
    for (int i = 0; i < 3; i++) begin
      if (ar_log.size() <= i) begin
        $display("Fetch %0d never appeared on AR", i);
        errors++;
      end else if (ar_log[i] != exp_ar[i]) begin
        report_mismatch("ar.addr", exp_ar[i], ar_log[i]);
      end
    end
    check_card(32'h4800, 32);
    finish_test("chain", e0);
  endtask

  task automatic test_invalid();
    int e0;
    e0 = errors;
    mem[32'h5000] = desc_word(1'b0, 1'b0, ACT_TRAN, 16'd64);
    mem[32'h5004] = 32'h4000;
    begin_walk(32'h5000);
    wait_irq();
    if (irq.error !== 1'b1) report_mismatch("irq.error", 1, irq.error);
    if (irq.complete !== 1'b0) report_mismatch("irq.complete", 0, irq.complete);
    if (card_rx.size() != 0) report_mismatch("card word count", 0, card_rx.size());
    irq_clear = 1'b1;
    @(negedge clock);
    irq_clear = 1'b0;
    @(negedge clock);
    if (irq !== 2'b00) report_mismatch("irq", 0, irq);
    finish_test("invalid_line", e0);
  endtask

  task automatic test_block_gap();
    int e0;
    e0 = errors;
    mem[32'h7000] = desc_word(1'b1, 1'b0, ACT_TRAN, 16'd64);
    mem[32'h7004] = 32'h4c00;
    mem[32'h7008] = desc_word(1'b1, 1'b0, ACT_TRAN, 16'd64);
    mem[32'h700c] = 32'h4e00;
    fill_data(32'h4c00, 16);
    gap_request = 1'b1;
    begin_walk(32'h7000);
    wait_irq();
    check_card(32'h4c00, 16);
    if (irq.complete !== 1'b1) report_mismatch("irq.complete", 1, irq.complete);
    foreach (ar_log[i]) begin
      if (ar_log[i] == 32'h7008) begin
        $display("Second descriptor was fetched despite the block gap");
        errors++;
      end
    end
    gap_request = 1'b0;
    finish_test("block_gap", e0);
  endtask

  initial begin
    reset        = 1'b0;
    start        = 1'b0;
    desc_base    = '0;
    to_mem       = 1'b0;
    gap_request  = 1'b0;
    irq_clear    = 1'b0;
    card_we      = 1'b0;
    ar_ready     = 1'b0;
    aw_ready     = 1'b0;
    w_ready      = 1'b0;
    r_valid      = 1'b0;
    r_last       = 1'b0;
    r_data       = '0;
    fifo_head    = '0;
    rd_active    = 1'b0;
    fetch_count  = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (8) @(negedge clock);
    reset = 1'b1;
    test_to_card();
    test_to_mem();
    test_chain();
    test_invalid();
    test_block_gap();
    errors += DUT.u_axi_checker.fail_count;
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("Simulation ran past its cycle limit");
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
src/adma_pkg.sv
src/adma_descriptor_fsm.sv
src/axi_read_engine.sv
src/axi_write_engine.sv
src/sd_adma_top.sv
tests/sd_adma_checker.sv
tests/sd_adma_tb.sv
